// ==== hw/osd_pkg.sv ====
// osd package: command codes, buffer and window constants, bus structs

package osd_pkg;

  // ------------------------------------------------------------
  // constants
  // ------------------------------------------------------------

  // buffer is 2048 bytes, 8 line groups of 256 columns
  localparam int unsigned BUF_AW = 11;

  // window placement, horizontal in half-rate counts
  localparam int unsigned OSD_H_START = 448;
  localparam int unsigned OSD_WIDTH   = 256;
  localparam int unsigned OSD_V_START = 128;
  localparam int unsigned OSD_HEIGHT  = 64;

  // chip 01, slow 01, fast 00, hrtmon off
  localparam logic [6:0] MEMORY_CFG_DEFAULT = 7'b0000101;

  // buffer command: bytes 0..2 are address filler, byte 3 holds the line group
  localparam int unsigned BUF_LINE_INDEX = 3;
  localparam int unsigned DAT_CNT_MAX    = 4;

  // ------------------------------------------------------------
  // host commands, upper six bits of the command byte
  // ------------------------------------------------------------
  typedef enum logic [5:0] {
    CMD_NOP          = 6'b0_000_00,
    CMD_RESET_CTRL   = 6'b0_000_10,
    CMD_OSD_CTRL     = 6'b0_010_10,
    CMD_CHIP_CFG     = 6'b0_000_01,
    CMD_CPU_CFG      = 6'b0_001_01,
    CMD_MEMORY_CFG   = 6'b0_010_01,
    CMD_VIDEO_CFG    = 6'b0_011_01,
    CMD_FLOPPY_CFG   = 6'b0_100_01,
    CMD_HARDDISK_CFG = 6'b0_101_01,
    CMD_JOYSTICK_CFG = 6'b0_110_01,
    CMD_OSD_BUFFER   = 6'b0_000_11
  } osd_cmd_e;

  // ------------------------------------------------------------
  // buses between blocks
  // ------------------------------------------------------------

  // one received spi byte
  typedef struct packed {
    logic       valid;
    logic       first;
    logic [7:0] data;
  } spi_byte_t;

  // one data byte routed to the register block
  typedef struct packed {
    logic       valid;
    osd_cmd_e   cmd;
    logic [2:0] index;
    logic [7:0] data;
  } reg_wr_t;

  // one byte into the osd buffer
  typedef struct packed {
    logic              valid;
    logic [BUF_AW-1:0] addr;
    logic [7:0]        data;
  } buf_wr_t;

  // configuration outputs toward the core
  typedef struct packed {
    logic [1:0] lr_filter;
    logic [1:0] hr_filter;
    logic [1:0] scanline;
    logic [1:0] dither;
    logic [6:0] memory_config;
    logic [4:0] chipset_config;
    logic [3:0] floppy_config;
    logic [2:0] ide_config;
    logic [3:0] cpu_config;
    logic [1:0] autofire_config;
    logic       cd32pad;
  } osd_cfg_t;

endpackage

// ==== hw/osd_spi_rx.sv ====
// osd_spi_rx: oversampled spi slave byte receiver with command-byte flag
`timescale 1ns/1ns

module osd_spi_rx import osd_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      scs_n,
  input  logic      sck,
  input  logic      sdi,
  output spi_byte_t rx
);

  // pin order {scs_n, sck, sdi}
  logic [2:0] pin_meta;
  logic [2:0] pin_sync;
  logic       sck_last;
  logic       sck_rise;
  logic [2:0] bit_cnt;
  logic [7:0] shift;
  logic       byte_done;
  logic       first_byte;

  // ------------------------------------------------------------
  // two-flop synchronizers
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      pin_meta <= 3'b100;
      pin_sync <= 3'b100;
      sck_last <= 1'b0;
    end else begin
      pin_meta <= {scs_n, sck, sdi};
      pin_sync <= pin_meta;
      sck_last <= pin_sync[1];
    end
  end

  // rising sck, only inside a frame
  assign sck_rise = pin_sync[1] && !sck_last && !pin_sync[2];

  // ------------------------------------------------------------
  // shifter, msb first
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (sck_rise)
      shift <= {shift[6:0], pin_sync[0]};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt    <= 3'd0;
      byte_done  <= 1'b0;
      first_byte <= 1'b1;
    end else begin
      byte_done <= sck_rise && (bit_cnt == 3'd7);
      // chip select high starts a new frame
      if (pin_sync[2])
        bit_cnt <= 3'd0;
      else if (sck_rise)
        bit_cnt <= bit_cnt + 3'd1;
      if (pin_sync[2])
        first_byte <= 1'b1;
      else if (byte_done)
        first_byte <= 1'b0;
    end
  end

  assign rx = '{valid: byte_done, first: first_byte, data: shift};

endmodule

// ==== hw/osd_cmd_decode.sv ====
// osd_cmd_decode: command latch, data byte counter, register and buffer write strobes
`timescale 1ns/1ns

module osd_cmd_decode import osd_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  spi_byte_t rx,
  output reg_wr_t   reg_wr,
  output buf_wr_t   buf_wr
);

  osd_cmd_e          cmd;
  logic [2:0]        index;
  logic              data_byte;
  logic              line_byte;
  logic              buf_active;
  logic [BUF_AW-1:0] wr_addr;

  assign data_byte = rx.valid && !rx.first;
  // byte that carries the line group of a buffer command
  assign line_byte = data_byte && (cmd == CMD_OSD_BUFFER) && (index == 3'(BUF_LINE_INDEX));

  // ------------------------------------------------------------
  // command and data byte counter
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd   <= CMD_NOP;
      index <= 3'd0;
    end else if (rx.valid && rx.first) begin
      cmd   <= osd_cmd_e'(rx.data[7:2]);
      index <= 3'd0;
    end else if (data_byte && (index != 3'(DAT_CNT_MAX))) begin
      index <= index + 3'd1;
    end
  end

  // register path, one cycle behind the spi byte
  always_ff @(posedge clk) begin
    if (reset)
      reg_wr.valid <= 1'b0;
    else
      reg_wr.valid <= data_byte;
  end

  always_ff @(posedge clk) begin
    reg_wr.cmd   <= cmd;
    reg_wr.index <= index;
    reg_wr.data  <= rx.data;
  end

  // ------------------------------------------------------------
  // buffer writes
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      buf_active   <= 1'b0;
      buf_wr.valid <= 1'b0;
    end else begin
      buf_wr.valid <= data_byte && buf_active;
      if (line_byte)
        buf_active <= 1'b1;
      else if (rx.valid && rx.first)
        buf_active <= 1'b0;
    end
  end

  // group times 256, wraps inside the buffer
  always_ff @(posedge clk) begin
    if (line_byte)
      wr_addr <= {rx.data[2:0], {(BUF_AW-3){1'b0}}};
    else if (data_byte && buf_active)
      wr_addr <= wr_addr + 1'b1;
  end

  always_ff @(posedge clk) begin
    buf_wr.addr <= wr_addr;
    buf_wr.data <= rx.data;
  end

endmodule

// ==== hw/osd_config_regs.sv ====
// osd_config_regs: host configuration, reset control, osd control and highlight registers
`timescale 1ns/1ns

module osd_config_regs import osd_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       sys_reset,
  input  reg_wr_t    reg_wr,
  output osd_cfg_t   cfg,
  output logic       osd_enable,
  output logic       key_disable,
  output logic       usrrst,
  output logic       cpurst,
  output logic       cpuhlt,
  output logic [3:0] highlight
);

  // staging copies, visible only through sys_reset
  logic [4:0] chip_stage;
  logic [3:0] cpu_stage;
  logic [6:0] mem_stage;
  logic [2:0] ide_stage;
  logic       wr0;

  // only the first data byte of a command carries a register value
  assign wr0 = reg_wr.valid && (reg_wr.index == 3'd0);

  // ------------------------------------------------------------
  // host written registers
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      {cpuhlt, cpurst, usrrst} <= 3'b110;
      {key_disable, osd_enable} <= 2'b00;
      {cfg.dither, cfg.hr_filter, cfg.lr_filter, cfg.scanline} <= 8'h00;
      {cfg.cd32pad, cfg.autofire_config} <= 3'b000;
      cfg.floppy_config <= 4'h0;
      chip_stage <= 5'h00;
      cpu_stage  <= 4'h0;
      mem_stage  <= MEMORY_CFG_DEFAULT;
      ide_stage  <= 3'h0;
    end else if (wr0) begin
      case (reg_wr.cmd)
        CMD_RESET_CTRL:   {cpuhlt, cpurst, usrrst} <= reg_wr.data[2:0];
        CMD_OSD_CTRL:     {key_disable, osd_enable} <= reg_wr.data[1:0];
        CMD_VIDEO_CFG:
          {cfg.dither, cfg.hr_filter, cfg.lr_filter, cfg.scanline} <= reg_wr.data;
        CMD_JOYSTICK_CFG: {cfg.cd32pad, cfg.autofire_config} <= reg_wr.data[2:0];
        CMD_FLOPPY_CFG:   cfg.floppy_config <= reg_wr.data[3:0];
        CMD_CPU_CFG:      cpu_stage <= reg_wr.data[3:0];
        CMD_CHIP_CFG:     chip_stage <= reg_wr.data[4:0];
        CMD_MEMORY_CFG:   mem_stage <= reg_wr.data[6:0];
        CMD_HARDDISK_CFG: ide_stage <= reg_wr.data[2:0];
        default: ;
      endcase
    end
  end

  // ------------------------------------------------------------
  // staged settings
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg.chipset_config <= 5'h00;
      cfg.ide_config     <= 3'h0;
      cfg.cpu_config     <= 4'h0;
      cfg.memory_config  <= MEMORY_CFG_DEFAULT;
    end else begin
      // cache, fast kick and hrtmon can change at run time
      cfg.cpu_config[3:2]  <= cpu_stage[3:2];
      cfg.memory_config[6] <= mem_stage[6];
      // the rest only while the core sits in reset
      if (sys_reset) begin
        cfg.chipset_config     <= chip_stage;
        cfg.ide_config         <= ide_stage;
        cfg.cpu_config[1:0]    <= cpu_stage[1:0];
        cfg.memory_config[5:0] <= mem_stage[5:0];
      end
    end
  end

  // highlight line, 4'b1000 is none
  always_ff @(posedge clk) begin
    if (reset || !osd_enable)
      highlight <= 4'b1000;
    else if (reg_wr.valid && (reg_wr.cmd == CMD_OSD_BUFFER) &&
             (reg_wr.index == 3'(BUF_LINE_INDEX)) && reg_wr.data[4])
      highlight <= reg_wr.data[3:0];
  end

endmodule

// ==== hw/osd_video.sv ====
// osd_video: beam counters, osd window, character column buffer and pixel output
`timescale 1ns/1ns

module osd_video import osd_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       sol,
  input  logic       sof,
  input  logic       osd_enable,
  input  logic [3:0] highlight,
  input  buf_wr_t    buf_wr,
  output logic       osd_blank,
  output logic       osd_pixel
);

  logic [10:0] hcnt;
  logic [8:0]  vcnt;
  logic [9:0]  hpos;
  logic [7:0]  xofs;
  logic [5:0]  vofs;
  logic        en_frame;
  logic        hwin;
  logic        vwin;
  logic        window;
  // read stage
  logic        win_d1;
  logic [2:0]  bit_d1;
  logic        inv_d1;
  logic [7:0]  rd_data;
  // 8 line groups of 256 columns, one byte is 8 pixel rows
  logic [7:0]  buf_mem [0:(2**BUF_AW)-1];

  // ------------------------------------------------------------
  // beam counters
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset || sol)
      hcnt <= 11'd0;
    else
      hcnt <= hcnt + 11'd1;
  end

  always_ff @(posedge clk) begin
    if (reset || sof)
      vcnt <= 9'd0;
    else if (sol)
      vcnt <= vcnt + 9'd1;
  end

  // enable only changes at frame start, no torn frames
  always_ff @(posedge clk) begin
    if (reset)
      en_frame <= 1'b0;
    else if (sof)
      en_frame <= osd_enable;
  end

  // ------------------------------------------------------------
  // window
  // ------------------------------------------------------------
  // osd runs at half the pixel clock
  assign hpos   = hcnt[10:1];
  assign hwin   = (hpos >= 10'(OSD_H_START)) && (hpos < 10'(OSD_H_START + OSD_WIDTH));
  assign vwin   = (vcnt >= 9'(OSD_V_START)) && (vcnt < 9'(OSD_V_START + OSD_HEIGHT));
  assign window = hwin && vwin && en_frame;
  assign xofs   = 8'(hpos - 10'(OSD_H_START));
  assign vofs   = 6'(vcnt - 9'(OSD_V_START));

  // ------------------------------------------------------------
  // buffer ram, one write and one read port
  // ------------------------------------------------------------
  // power-up contents cleared, block ram init
  initial begin
    for (int i = 0; i < 2**BUF_AW; i++)
      buf_mem[i] = 8'h00;
  end

  always_ff @(posedge clk) begin
    if (buf_wr.valid)
      buf_mem[buf_wr.addr] <= buf_wr.data;
  end

  always_ff @(posedge clk) begin
    rd_data <= buf_mem[{vofs[5:3], xofs}];
    bit_d1  <= vofs[2:0];
    inv_d1  <= (highlight == {1'b0, vofs[5:3]});
  end

  // ------------------------------------------------------------
  // outputs, two clocks behind the counters
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      win_d1    <= 1'b0;
      osd_blank <= 1'b0;
      osd_pixel <= 1'b0;
    end else begin
      win_d1    <= window;
      osd_blank <= win_d1;
      osd_pixel <= win_d1 && (rd_data[bit_d1] ^ inv_d1);
    end
  end

endmodule

// ==== hw/userio_osd.sv ====
// userio_osd: osd controller top level, spi receiver, decoder, registers and video
`timescale 1ns/1ns

module userio_osd import osd_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     sys_reset,
  input  logic     scs_n,
  input  logic     sck,
  input  logic     sdi,
  input  logic     sol,
  input  logic     sof,
  output osd_cfg_t cfg,
  output logic     osd_enable,
  output logic     key_disable,
  output logic     usrrst,
  output logic     cpurst,
  output logic     cpuhlt,
  output logic     osd_blank,
  output logic     osd_pixel
);

  spi_byte_t  rx;
  reg_wr_t    reg_wr;
  buf_wr_t    buf_wr;
  logic [3:0] highlight;

  // ------------------------------------------------------------
  // host side
  // ------------------------------------------------------------
  osd_spi_rx u_spi_rx (
    .clk   (clk),
    .reset (reset),
    .scs_n (scs_n),
    .sck   (sck),
    .sdi   (sdi),
    .rx    (rx)
  );

  osd_cmd_decode u_cmd_decode (
    .clk    (clk),
    .reset  (reset),
    .rx     (rx),
    .reg_wr (reg_wr),
    .buf_wr (buf_wr)
  );

  osd_config_regs u_config_regs (
    .clk         (clk),
    .reset       (reset),
    .sys_reset   (sys_reset),
    .reg_wr      (reg_wr),
    .cfg         (cfg),
    .osd_enable  (osd_enable),
    .key_disable (key_disable),
    .usrrst      (usrrst),
    .cpurst      (cpurst),
    .cpuhlt      (cpuhlt),
    .highlight   (highlight)
  );

  // ------------------------------------------------------------
  // video side
  // ------------------------------------------------------------
  osd_video u_video (
    .clk        (clk),
    .reset      (reset),
    .sol        (sol),
    .sof        (sof),
    .osd_enable (osd_enable),
    .highlight  (highlight),
    .buf_wr     (buf_wr),
    .osd_blank  (osd_blank),
    .osd_pixel  (osd_pixel)
  );

endmodule

// ==== bench/userio_osd_sva.sv ====
// userio_osd_sva: assertions on the osd top level outputs, bound to userio_osd
`timescale 1ns/1ns

module userio_osd_sva import osd_pkg::*; (
  input logic     clk,
  input logic     reset,
  input logic     sol,
  input logic     sof,
  input logic     osd_enable,
  input logic     osd_blank,
  input logic     osd_pixel,
  input logic     key_disable,
  input logic     usrrst,
  input logic     cpurst,
  input logic     cpuhlt,
  input osd_cfg_t cfg
);

  // enable low since the last frame start
  logic        dark;
  // clocks since the last line start, holds at the top
  logic [10:0] line_clk;
  int          err_cnt = 0;

  always_ff @(posedge clk) begin
    if (reset)
      dark <= 1'b0;
    else if (sof)
      dark <= !osd_enable;
    else if (osd_enable)
      dark <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (reset || sol)
      line_clk <= 11'd0;
    else if (line_clk != 11'h7ff)
      line_clk <= line_clk + 11'd1;
  end

  // ------------------------------------------------------------
  // properties
  // ------------------------------------------------------------
  // left edge of the window at 2 * OSD_H_START clocks, half rate
  window_left_edge: assert property (@(posedge clk) disable iff (reset)
    (line_clk < 11'(2 * OSD_H_START)) |-> !osd_blank && !osd_pixel)
  else begin
    $error("osd output left of the osd window");
    err_cnt++;
  end

  // blank trails the window by two clocks
  no_blank_when_off: assert property (@(posedge clk) disable iff (reset)
    dark && $past(dark, 2) |-> !osd_blank)
  else begin
    $error("osd_blank high in a frame with the osd disabled");
    err_cnt++;
  end

  outputs_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown({cfg, osd_enable, key_disable, usrrst, cpurst, cpuhlt, osd_blank, osd_pixel}))
  else begin
    $error("unknown value on an osd output");
    err_cnt++;
  end

endmodule

bind userio_osd userio_osd_sva u_sva (.*);

// ==== bench/userio_osd_tb.sv ====
// userio_osd_tb: spi host, beam timing, register table, pixel counts and checks
`timescale 1ns/1ns

module userio_osd_tb import osd_pkg::*; ();

  localparam int HALF_CLKS   = 8;
  localparam int BYTE_CLKS   = 16 * HALF_CLKS;
  localparam int LINE_CLKS   = 1600;
  localparam int FRAME_LINES = 200;
  localparam int FRAME_CLKS  = LINE_CLKS * FRAME_LINES;
  localparam int NUM_STEPS   = 15;
  localparam int STEP_CLKS   = 4 * BYTE_CLKS + 64;
  // table, one buffer frame of ~260 bytes, three checks of two frames plus margin
  localparam int TIMEOUT_CLKS = NUM_STEPS * STEP_CLKS + 300 * BYTE_CLKS + 8 * FRAME_CLKS;
  localparam int GROUP       = 2;

  typedef logic [7:0] byte_q_t [$];

  // stimulus, then expected outputs once the frame has ended
  typedef struct packed {
    osd_cmd_e   cmd;
    logic [7:0] data;
    logic       pulse;
    logic [7:0] video;
    logic [6:0] mem;
    logic [4:0] chip;
    logic [3:0] floppy;
    logic [2:0] ide;
    logic [3:0] cpu;
    logic [2:0] joy;
    logic [4:0] ctrl;
  } step_t;

  logic       clk;
  logic       reset;
  logic       sys_reset;
  logic       scs_n;
  logic       sck;
  logic       sdi;
  logic       sol = 1'b0;
  logic       sof = 1'b0;
  osd_cfg_t   cfg;
  logic       osd_enable;
  logic       key_disable;
  logic       usrrst;
  logic       cpurst;
  logic       cpuhlt;
  logic       osd_blank;
  logic       osd_pixel;

  step_t      steps [NUM_STEPS];
  logic [7:0] pattern [256];
  // beam position and per line counts of the last lines seen
  int         hpix = 0;
  int         vline = 0;
  int         frame_cnt = 0;
  int         blank_acc = 0;
  int         pix_acc = 0;
  int         line_blank [FRAME_LINES];
  int         line_pix [FRAME_LINES];
  int         cycles = 0;

  userio_osd u_dut (.*);

  always #5 clk = ~clk;

  // ------------------------------------------------------------
  // beam timing and pixel counting
  // ------------------------------------------------------------
  always @(posedge clk) begin
    if (hpix == LINE_CLKS - 1) begin
      hpix  <= 0;
      vline <= (vline == FRAME_LINES - 1) ? 0 : vline + 1;
      sol   <= 1'b1;
      sof   <= (vline == FRAME_LINES - 1);
      line_blank[vline] <= blank_acc;
      line_pix[vline]   <= pix_acc;
      blank_acc <= int'(osd_blank);
      pix_acc   <= int'(osd_pixel);
      if (vline == FRAME_LINES - 1)
        frame_cnt <= frame_cnt + 1;
    end else begin
      hpix      <= hpix + 1;
      sol       <= 1'b0;
      sof       <= 1'b0;
      blank_acc <= blank_acc + int'(osd_blank);
      pix_acc   <= pix_acc + int'(osd_pixel);
    end
  end

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CLKS) begin
      $display("Timeout: the test did not finish within %0d clock cycles", TIMEOUT_CLKS);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  // bound checker watch
  always @(posedge clk) begin
    if (u_dut.u_sva.err_cnt != 0) begin
      $display("An assertion in the bound checker u_sva failed, see the error above");
      $display("Simulation failed");
      $fatal(1);
    end
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // expected cfg from the table columns
  function automatic osd_cfg_t cfg_of(input step_t s);
    osd_cfg_t c;
    {c.dither, c.hr_filter, c.lr_filter, c.scanline} = s.video;
    c.memory_config   = s.mem;
    c.chipset_config  = s.chip;
    c.floppy_config   = s.floppy;
    c.ide_config      = s.ide;
    c.cpu_config      = s.cpu;
    c.cd32pad         = s.joy[2];
    c.autofire_config = s.joy[1:0];
    return c;
  endfunction

  // bytes of the pattern with a given row bit set
  function automatic int bits_set(input int row);
    int n;
    n = 0;
    for (int i = 0; i < 256; i++)
      n += int'(pattern[i][row]);
    return n;
  endfunction

  task automatic check_cfg(input string name, input osd_cfg_t exp, input osd_cfg_t act);
    if (act !== exp) begin
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic check_outputs(input string tag, input step_t s);
    check_cfg({"cfg ", tag}, cfg_of(s), cfg);
    check_bit({"osd_enable ", tag}, s.ctrl[4], osd_enable);
    check_bit({"key_disable ", tag}, s.ctrl[3], key_disable);
    check_bit({"usrrst ", tag}, s.ctrl[2], usrrst);
    check_bit({"cpurst ", tag}, s.ctrl[1], cpurst);
    check_bit({"cpuhlt ", tag}, s.ctrl[0], cpuhlt);
  endtask

  // ------------------------------------------------------------
  // spi host, msb first, sck low while idle
  // ------------------------------------------------------------
  task automatic spi_frame(input osd_cmd_e cmd, input byte_q_t data);
    byte_q_t bytes;
    bytes = data;
    bytes.push_front({cmd, 2'b00});
    @(posedge clk);
    scs_n <= 1'b0;
    repeat (HALF_CLKS) @(posedge clk);
    foreach (bytes[i]) begin
      for (int b = 7; b >= 0; b--) begin
        sck <= 1'b0;
        sdi <= bytes[i][b];
        repeat (HALF_CLKS) @(posedge clk);
        sck <= 1'b1;
        repeat (HALF_CLKS) @(posedge clk);
      end
    end
    sck <= 1'b0;
    repeat (HALF_CLKS) @(posedge clk);
    scs_n <= 1'b1;
    // receiver, decoder and register stages are a handful of clocks
    repeat (2 * HALF_CLKS) @(posedge clk);
  endtask

  task automatic wait_frames(input int n);
    int target;
    target = frame_cnt + n;
    while (frame_cnt < target)
      @(posedge clk);
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    byte_q_t     data;
    logic [31:0] seed;
    int          n;
    step_t       after_reset;
    clk       = 1'b0;
    reset     = 1'b1;
    sys_reset = 1'b0;
    scs_n     = 1'b1;
    sck       = 1'b0;
    sdi       = 1'b0;
    seed      = 32'd10997;
    // cmd, data, sys_reset pulse | video, mem, chip, floppy, ide, cpu, joy, ctrl
    // ctrl is {osd_enable, key_disable, usrrst, cpurst, cpuhlt}
    after_reset = '{CMD_NOP, 0, 0, 0, 'h05, 0, 0, 0, 0, 0, 'b00011};
    steps[0]  = '{CMD_VIDEO_CFG, 'h5a, 0, 'h5a, 'h05, 0, 0, 0, 0, 0, 'b00011};
    steps[1]  = '{CMD_FLOPPY_CFG, 'hf9, 0, 'h5a, 'h05, 0, 9, 0, 0, 0, 'b00011};
    steps[2]  = '{CMD_JOYSTICK_CFG, 'h06, 0, 'h5a, 'h05, 0, 9, 0, 0, 6, 'b00011};
    steps[3]  = '{CMD_RESET_CTRL, 'h04, 0, 'h5a, 'h05, 0, 9, 0, 0, 6, 'b00001};
    steps[4]  = '{CMD_OSD_CTRL, 'h02, 0, 'h5a, 'h05, 0, 9, 0, 0, 6, 'b01001};
    // staged fields hold, cpu[3:2] and mem[6] follow at once
    steps[5]  = '{CMD_CPU_CFG, 'h0f, 0, 'h5a, 'h05, 0, 9, 0, 'hc, 6, 'b01001};
    steps[6]  = '{CMD_MEMORY_CFG, 'h7a, 0, 'h5a, 'h45, 0, 9, 0, 'hc, 6, 'b01001};
    steps[7]  = '{CMD_CHIP_CFG, 'h1b, 0, 'h5a, 'h45, 0, 9, 0, 'hc, 6, 'b01001};
    steps[8]  = '{CMD_HARDDISK_CFG, 'h05, 0, 'h5a, 'h45, 0, 9, 0, 'hc, 6, 'b01001};
    steps[9]  = '{osd_cmd_e'(6'b011101), 'hff, 0, 'h5a, 'h45, 0, 9, 0, 'hc, 6, 'b01001};
    steps[10] = '{CMD_NOP, 'hff, 1, 'h5a, 'h7a, 'h1b, 9, 5, 'hf, 6, 'b01001};
    steps[11] = '{CMD_CPU_CFG, 'h01, 0, 'h5a, 'h7a, 'h1b, 9, 5, 'h3, 6, 'b01001};
    steps[12] = '{CMD_NOP, 'h00, 1, 'h5a, 'h7a, 'h1b, 9, 5, 'h1, 6, 'b01001};
    steps[13] = '{CMD_RESET_CTRL, 'h00, 0, 'h5a, 'h7a, 'h1b, 9, 5, 'h1, 6, 'b01000};
    steps[14] = '{CMD_OSD_CTRL, 'h01, 0, 'h5a, 'h7a, 'h1b, 9, 5, 'h1, 6, 'b10000};

    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_outputs("after reset", after_reset);

    // register table, a trailing inverted byte must be ignored
    for (int i = 0; i < NUM_STEPS; i++) begin
      data.delete();
      data.push_back(steps[i].data);
      data.push_back(~steps[i].data);
      spi_frame(steps[i].cmd, data);
      if (steps[i].pulse) begin
        sys_reset <= 1'b1;
        repeat (2) @(posedge clk);
        sys_reset <= 1'b0;
        repeat (2) @(posedge clk);
      end
      check_outputs($sformatf("after step %0d", i), steps[i]);
    end

    // buffer fill for group 2, no highlight
    data.delete();
    data = '{8'h00, 8'h00, 8'h00, 8'(GROUP)};
    for (int i = 0; i < 256; i++) begin
      seed = lcg_next(seed);
      pattern[i] = seed[23:16];
      data.push_back(pattern[i]);
    end
    spi_frame(CMD_OSD_BUFFER, data);
    wait_frames(2);
    for (int v = 0; v < OSD_HEIGHT; v++)
      check_count($sformatf("osd_blank cycles line %0d", v), 512,
                  line_blank[OSD_V_START + v]);
    for (int v = 0; v < 8; v++) begin
      n = 2 * bits_set(v);
      check_count($sformatf("osd_pixel cycles line %0d", GROUP * 8 + v), n,
                  line_pix[OSD_V_START + GROUP * 8 + v]);
    end

    // same group highlighted, header only so the buffer stays
    data = '{8'h00, 8'h00, 8'h00, 8'h10 | 8'(GROUP)};
    spi_frame(CMD_OSD_BUFFER, data);
    wait_frames(2);
    for (int v = 0; v < 8; v++) begin
      n = 512 - 2 * bits_set(v);
      check_count($sformatf("inverted osd_pixel cycles line %0d", GROUP * 8 + v), n,
                  line_pix[OSD_V_START + GROUP * 8 + v]);
    end

    // osd off, a whole frame without blanking
    data = '{8'h00, 8'hff};
    spi_frame(CMD_OSD_CTRL, data);
    check_bit("osd_enable after disable", 1'b0, osd_enable);
    wait_frames(2);
    n = 0;
    for (int l = 0; l < FRAME_LINES; l++)
      n += line_blank[l];
    check_count("osd_blank cycles in disabled frame", 0, n);

    if (u_dut.u_sva.err_cnt != 0) begin
      $display("Assertion failures during the run: %0d", u_dut.u_sva.err_cnt);
      $display("Simulation failed");
      $fatal(1);
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

// ==== build.f ====
hw/osd_pkg.sv
hw/osd_spi_rx.sv
hw/osd_cmd_decode.sv
hw/osd_config_regs.sv
hw/osd_video.sv
hw/userio_osd.sv
bench/userio_osd_sva.sv
bench/userio_osd_tb.sv

// ==== Bender.yml ====
package:
  name: userio_osd

sources:
  - hw/osd_pkg.sv
  - hw/osd_spi_rx.sv
  - hw/osd_cmd_decode.sv
  - hw/osd_config_regs.sv
  - hw/osd_video.sv
  - hw/userio_osd.sv
  - target: simulation
    files:
      - bench/userio_osd_sva.sv
      - bench/userio_osd_tb.sv
